//--- Makefile
# Verilator build and run of the division unit testbench

SRCS := $(filter-out +%,$(shell cat compile.f)) rtl/div_macros.svh
SIM  := obj_dir/Vdiv_unit_tb

.PHONY: all run clean

all: $(SIM)

$(SIM): compile.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module div_unit_tb -f compile.f -o Vdiv_unit_tb

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

//--- compile.f
+incdir+rtl
rtl/div_types_pkg.sv
rtl/div_flow_pkg.sv
rtl/div_issue_stage.sv
rtl/div_subshift_core.sv
rtl/div_result_stage.sv
rtl/div_unit_top.sv
tb/div_unit_tb.sv

//--- rtl/div_flow_pkg.sv
`default_nettype none

`include "div_macros.svh"

package div_flow_pkg;
   import div_types_pkg::*;

   localparam int CREDIT_MAX = (`DIV_REQ_CREDITS > `DIV_RSP_CREDITS) ?
                               `DIV_REQ_CREDITS : `DIV_RSP_CREDITS;

   typedef struct packed {
      tag_t      tag;
      dividend_t dividend;
      divisor_t  divisor;
   } div_req_t;

   typedef struct packed {
      tag_t      tag;
      dividend_t dividend;
      divisor_t  divisor;
      logic      dbz;       // divisor was zero
   } div_job_t;

   typedef struct packed {
      tag_t       tag;
      quotient_t  quotient;
      remainder_t remainder;
      logic       dbz;
   } div_rsp_t;

   typedef logic [$clog2(CREDIT_MAX + 1)-1:0] credit_cnt_t;

endpackage

`default_nettype wire

//--- rtl/div_issue_stage.sv
`default_nettype none

`include "div_macros.svh"

module div_issue_stage import div_types_pkg::*, div_flow_pkg::*; (
   input  wire logic     clk_i,
   input  wire logic     rst_i,

   input  wire logic     req_valid_i,
   input  wire div_req_t req_i,
   output logic          req_credit_o,

   input  wire logic     core_busy_i,
   input  wire logic     res_space_i,
   output logic          start_o,
   output div_job_t      job_o
);

   localparam int DEPTH = `DIV_REQ_CREDITS;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

   div_job_t         slots_q [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   credit_cnt_t      count_q;   // occupied slots
   logic             empty;
   logic             full;
   logic             push;
   logic             pop;
   div_job_t         job_in;

   assign empty = (count_q == '0);
   assign full  = (count_q == credit_cnt_t'(DEPTH));
   assign push  = req_valid_i;  // sender only sends with a credit in hand
   assign pop   = start_o;

   // flag zero divisors on the way in
   always_comb begin
      job_in.tag      = req_i.tag;
      job_in.dividend = req_i.dividend;
      job_in.divisor  = req_i.divisor;
      job_in.dbz      = (req_i.divisor == divisor_t'(0));
   end

   // need a job, an idle core and a reserved slot in the result queue
   assign start_o      = !empty && !core_busy_i && res_space_i;
   assign req_credit_o = pop;  // slot freed, give the credit back
   assign job_o        = slots_q[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;  // idle, or push and pop together
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         slots_q[wr_ptr_q] <= job_in;
      end
   end

   // a full buffer means the sender spent a credit it never had
   a_req_has_credit: assert property (@(posedge clk_i) disable iff (rst_i)
      req_valid_i |-> !full)
      else $error("request arrived with the buffer full");

endmodule

`default_nettype wire

//--- rtl/div_macros.svh
`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// operand widths
`define DIV_DIVIDEND_W 32  // also the quotient width
`define DIV_DIVISOR_W  32  // also the remainder width
`define DIV_TAG_W      4

// buffer depths
`define DIV_REQ_CREDITS 2  // request slots, sender starts with this many credits
`define DIV_RSP_CREDITS 2  // receiver slots, unit starts with this many credits
`define DIV_RES_DEPTH   2

`endif

//--- rtl/div_result_stage.sv
`default_nettype none

`include "div_macros.svh"

module div_result_stage import div_types_pkg::*, div_flow_pkg::*; (
   input  wire logic     clk_i,
   input  wire logic     rst_i,

   input  wire logic     start_i,
   input  wire logic     done_i,
   input  wire div_rsp_t rsp_i,
   output logic          res_space_o,

   output logic          rsp_valid_o,
   output div_rsp_t      rsp_o,
   input  wire logic     rsp_credit_i
);

   localparam int DEPTH = `DIV_RES_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [PTR_W-1:0] PTR_LAST  = PTR_W'(DEPTH - 1);
   localparam logic [CNT_W:0]   RES_LIMIT = DEPTH[CNT_W:0];

   div_rsp_t         queue_q [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] occ_q;       // results waiting to leave
   logic [CNT_W-1:0] inflight_q;  // jobs still in the core
   credit_cnt_t      credit_q;    // free slots at the receiver
   logic [CNT_W:0]   reserved;
   div_rsp_t         rsp_in;
   logic             pop;

   // every job in the core already owns a queue slot, so done never stalls
   assign reserved    = {1'b0, occ_q} + {1'b0, inflight_q};
   assign res_space_o = (reserved < RES_LIMIT);

   always_comb begin
      rsp_in = rsp_i;
      if (rsp_i.dbz) begin
         rsp_in.quotient = {$bits(quotient_t){1'b1}};
         // remainder field already holds the dividend
      end
   end

   assign pop         = rsp_valid_o;
   assign rsp_valid_o = (occ_q != '0) && (credit_q != '0);
   assign rsp_o       = queue_q[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         occ_q      <= '0;
         inflight_q <= '0;
         credit_q   <= credit_cnt_t'(`DIV_RSP_CREDITS);
      end else begin
         if (done_i) begin
            wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({done_i, pop})
            2'b10:   occ_q <= occ_q + 1'b1;
            2'b01:   occ_q <= occ_q - 1'b1;
            default: occ_q <= occ_q;
         endcase
         case ({start_i, done_i})
            2'b10:   inflight_q <= inflight_q + 1'b1;
            2'b01:   inflight_q <= inflight_q - 1'b1;
            default: inflight_q <= inflight_q;
         endcase
         case ({rsp_credit_i, pop})
            2'b10:   credit_q <= credit_q + 1'b1;
            2'b01:   credit_q <= credit_q - 1'b1;
            default: credit_q <= credit_q;  // returned and spent at once
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (done_i) begin
         queue_q[wr_ptr_q] <= rsp_in;
      end
   end

   // receiver handed back more credits than it was given
   a_credit_bound: assert property (@(posedge clk_i) disable iff (rst_i)
      credit_q <= credit_cnt_t'(`DIV_RSP_CREDITS))
      else $error("output credits above the receiver depth");

   a_done_room: assert property (@(posedge clk_i) disable iff (rst_i)
      done_i |-> (occ_q != CNT_W'(DEPTH)))
      else $error("result arrived with the queue full");

endmodule

`default_nettype wire

//--- rtl/div_subshift_core.sv
`default_nettype none

`include "div_macros.svh"

module div_subshift_core import div_types_pkg::*, div_flow_pkg::*; (
   input  wire logic     clk_i,
   input  wire logic     rst_i,

   input  wire logic     start_i,
   input  wire div_job_t job_i,
   output logic          busy_o,
   output logic          done_o,
   output div_rsp_t      rsp_o
);

   localparam int DIVIDEND_W = `DIV_DIVIDEND_W;
   localparam int DIVISOR_W  = `DIV_DIVISOR_W;
   localparam int DQR_W      = DIVISOR_W + DIVIDEND_W;

   core_state_t          state_q;
   step_cnt_t            step_q;
   div_job_t             job_q;     // operands as latched
   logic [DQR_W-1:0]     dqr_q;     // partial remainder above dividend/quotient
   logic [DIVISOR_W:0]   window;    // remainder with the next dividend bit
   logic [DIVISOR_W+1:0] diff;
   logic [DIVISOR_W:0]   keep;
   logic                 fits;
   logic [DQR_W-1:0]     dqr_step;
   quotient_t            quotient;
   remainder_t           remainder;

   assign window = dqr_q[DQR_W-1 -: DIVISOR_W+1];
   assign diff   = {1'b0, window} - {2'b00, job_q.divisor};
   assign fits   = !diff[DIVISOR_W+1];  // no borrow

   // restoring step, on a borrow the window goes back unchanged
   always_comb begin
      keep     = fits ? diff[DIVISOR_W:0] : window;
      dqr_step = {keep[DIVISOR_W-1:0], dqr_q[DIVIDEND_W-2:0], fits};
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= CORE_IDLE;
         step_q  <= '0;
      end else begin
         case (state_q)
            CORE_IDLE: begin
               if (start_i) begin
                  state_q <= CORE_RUN;
                  step_q  <= '0;
               end
            end
            CORE_RUN: begin
               step_q <= step_q + 1'b1;
               if (step_q == step_cnt_t'(DIVIDEND_W - 1)) begin
                  state_q <= CORE_DONE;  // last quotient bit goes in this cycle
               end
            end
            CORE_DONE: state_q <= CORE_IDLE;
            default:   state_q <= CORE_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == CORE_IDLE && start_i) begin
         job_q <= job_i;
         dqr_q <= {{DIVISOR_W{1'b0}}, job_i.dividend};
      end else if (state_q == CORE_RUN) begin
         dqr_q <= dqr_step;
      end
   end

   assign quotient  = dqr_q[DIVIDEND_W-1:0];
   assign remainder = dqr_q[DQR_W-1 -: DIVISOR_W];

   assign busy_o = (state_q != CORE_IDLE);
   assign done_o = (state_q == CORE_DONE);

   always_comb begin
      rsp_o.tag      = job_q.tag;
      rsp_o.quotient = quotient;
      // dbz jobs hand the raw dividend on for the result stage
      rsp_o.remainder = job_q.dbz ? remainder_t'(job_q.dividend) : remainder;
      rsp_o.dbz       = job_q.dbz;
   end

   // issue stage must wait for the core to drop busy
   a_start_idle: assert property (@(posedge clk_i) disable iff (rst_i)
      start_i |-> !busy_o)
      else $error("start while the core is busy");

   // each done cycle lies one step count plus one after its start
   a_done_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
      done_o |-> $past(start_i, DIVIDEND_W + 1))
      else $error("done pulse out of step with its start");

endmodule

`default_nettype wire

//--- rtl/div_types_pkg.sv
`default_nettype none

`include "div_macros.svh"

package div_types_pkg;

   // operand and result vectors
   typedef logic [`DIV_DIVIDEND_W-1:0] dividend_t;
   typedef logic [`DIV_DIVISOR_W-1:0]  divisor_t;
   typedef logic [`DIV_DIVIDEND_W-1:0] quotient_t;
   typedef logic [`DIV_DIVISOR_W-1:0]  remainder_t;
   typedef logic [`DIV_TAG_W-1:0]      tag_t;

   // covers 0 up to dividend width + 1
   typedef logic [$clog2(`DIV_DIVIDEND_W + 2)-1:0] step_cnt_t;

   typedef enum logic [1:0] {
      CORE_IDLE,
      CORE_RUN,   // one quotient bit per cycle
      CORE_DONE
   } core_state_t;

endpackage

`default_nettype wire

//--- rtl/div_unit_top.sv
`default_nettype none

`include "div_macros.svh"

module div_unit_top import div_flow_pkg::*; (
   input  wire logic     clk_i,
   input  wire logic     rst_i,

   // request link, credit based
   input  wire logic     req_valid_i,
   input  wire div_req_t req_i,
   output logic          req_credit_o,

   // response link, credit based
   output logic          rsp_valid_o,
   output div_rsp_t      rsp_o,
   input  wire logic     rsp_credit_i
);

   logic     core_start;
   div_job_t core_job;
   logic     core_busy;
   logic     core_done;
   div_rsp_t core_rsp;
   logic     res_space;  // result slot free for the next job

   div_issue_stage u_issue (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_valid_i (req_valid_i),
      .req_i       (req_i),
      .req_credit_o(req_credit_o),
      .core_busy_i (core_busy),
      .res_space_i (res_space),
      .start_o     (core_start),
      .job_o       (core_job)
   );

   div_subshift_core u_core (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .start_i(core_start),
      .job_i  (core_job),
      .busy_o (core_busy),
      .done_o (core_done),
      .rsp_o  (core_rsp)
   );

   div_result_stage u_result (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .start_i     (core_start),  // reserves a slot per job
      .done_i      (core_done),
      .rsp_i       (core_rsp),
      .res_space_o (res_space),
      .rsp_valid_o (rsp_valid_o),
      .rsp_o       (rsp_o),
      .rsp_credit_i(rsp_credit_i)
   );

endmodule

`default_nettype wire

//--- tb/div_unit_tb.sv
`default_nettype none

`include "div_macros.svh"

module div_unit_tb import div_types_pkg::*, div_flow_pkg::*; ();

   localparam int N_TESTS     = 120;
   localparam int HOLD_AT     = N_TESTS / 2;  // responses seen before credits stop
   localparam int HOLD_CYCLES = 400;
   localparam int CLK_PERIOD  = 100;
   localparam int TIMEOUT     = (N_TESTS * 40 + HOLD_CYCLES + 500) * CLK_PERIOD;

   logic     clk_i;
   logic     rst_i;
   logic     req_valid_i;
   div_req_t req_i;
   logic     req_credit_o;
   logic     rsp_valid_o;
   div_rsp_t rsp_o;
   logic     rsp_credit_i;

   logic [31:0] lfsr_q;
   div_rsp_t    exp_q[$];     // expected responses in request order
   int          sent;
   int          received;
   int          tx_credits;   // sender credits in hand
   int          rx_credits;   // credits the unit holds, as the receiver sees it
   int          pending_ret;  // receiver slots still to be freed
   int          ret_delay;
   int          hold_left;    // cycles of withheld credits
   logic        hold_done;
   int          idle_left;

   div_unit_top dut (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_valid_i (req_valid_i),
      .req_i       (req_i),
      .req_credit_o(req_credit_o),
      .rsp_valid_o (rsp_valid_o),
      .rsp_o       (rsp_o),
      .rsp_credit_i(rsp_credit_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("Something failed");
      $fatal(1, "run aborted");
   endtask

   task automatic value_error(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      $display("ERR t=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
      stop_with_failure("wrong value on the response link");
   endtask

   // galois form, shifts right, one step per bit
   function automatic logic lfsr_bit();
      logic out;
      out    = lfsr_q[0];
      lfsr_q = {1'b0, lfsr_q[31:1]} ^ (out ? 32'h8020_0003 : 32'h0);
      return out;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         val = {val[30:0], lfsr_bit()};
      end
      return val;
   endfunction

   // expected result straight from the division rules
   function automatic div_rsp_t div_ref(input tag_t tag, input dividend_t dividend,
                                        input divisor_t divisor);
      div_rsp_t r;
      r.tag = tag;
      if (divisor == '0) begin
         r.quotient  = '1;
         r.remainder = remainder_t'(dividend);
         r.dbz       = 1'b1;
      end else begin
         r.quotient  = quotient_t'(dividend / divisor);
         r.remainder = remainder_t'(dividend % divisor);
         r.dbz       = 1'b0;
      end
      return r;
   endfunction

   function automatic div_req_t make_request(input int idx);
      div_req_t   r;
      logic [2:0] mode;
      mode       = 3'(rand_bits(3));
      r.tag      = tag_t'(idx);
      r.dividend = rand_bits(32);
      r.divisor  = rand_bits(32);
      case (mode)
         3'd0:    r.divisor  = '0;
         3'd1:    r.divisor  = divisor_t'(1);
         3'd2:    r.dividend = dividend_t'(rand_bits(8));  // mostly below the divisor
         3'd3:    r.divisor  = divisor_t'(rand_bits(6));   // small, zero now and then
         3'd4:    r.dividend = dividend_t'(r.divisor);
         default: r.divisor  = r.divisor;
      endcase
      return r;
   endfunction

   initial begin
      lfsr_q       = 32'h0b7c_ec7c;
      rst_i        = 1'b1;
      req_valid_i  = 1'b0;
      req_i        = '0;
      rsp_credit_i = 1'b0;
      sent         = 0;
      received     = 0;
      tx_credits   = `DIV_REQ_CREDITS;
      rx_credits   = `DIV_RSP_CREDITS;
      pending_ret  = 0;
      ret_delay    = 0;
      hold_left    = 0;
      hold_done    = 1'b0;
      idle_left    = 4;  // quiet cycles after reset
      repeat (2) @(posedge clk_i);
      rst_i <= 1'b0;
      wait (received == N_TESTS);
      repeat (60) @(posedge clk_i);  // time for a stray or duplicate response
      if (exp_q.size() == 0 && sent == N_TESTS && tx_credits == `DIV_REQ_CREDITS &&
          rx_credits == `DIV_RSP_CREDITS && pending_ret == 0) begin
         $display("Everything OK");
         $finish;
      end else begin
         stop_with_failure("responses or credits out of balance at the end");
      end
   end

   // sender and receiver models, one process keeps the random stream ordered
   always @(posedge clk_i) begin
      div_req_t req;
      req_valid_i  <= 1'b0;
      rsp_credit_i <= 1'b0;
      if (!rst_i) begin
         if (idle_left > 0) begin
            idle_left--;
         end else if (sent < N_TESTS && tx_credits > 0) begin
            if (rand_bits(1) == 32'd1) begin
               req = make_request(sent);
               exp_q.push_back(div_ref(req.tag, req.dividend, req.divisor));
               req_i       <= req;
               req_valid_i <= 1'b1;
               tx_credits--;
               sent++;
            end
         end
         if (hold_left > 0) begin
            hold_left--;
         end else if (pending_ret > 0) begin
            if (ret_delay == 0) begin
               rsp_credit_i <= 1'b1;  // one receiver slot freed
               pending_ret--;
               ret_delay = int'(rand_bits(4));
            end else begin
               ret_delay--;
            end
         end
      end
   end

   // outputs are sampled mid cycle, away from the driving edge
   always @(negedge clk_i) begin
      div_rsp_t want;
      if (!rst_i) begin
         if (sent == 0) begin
            assert (!req_credit_o && !rsp_valid_o)
               else stop_with_failure("credit or response seen before any request");
         end
         if (req_credit_o) begin
            tx_credits++;
            assert (tx_credits <= `DIV_REQ_CREDITS)
               else stop_with_failure("sender got back more credits than it spent");
         end
         if (rsp_valid_o) begin
            // a credit pulse of this cycle reaches the unit only at the next edge
            assert (rx_credits > 0)
               else stop_with_failure("response sent without a receiver credit");
            assert (exp_q.size() > 0)
               else stop_with_failure("response arrived with no request outstanding");
            want = exp_q.pop_front();
            assert (rsp_o.tag == want.tag)
               else value_error("rsp_o.tag", 64'(want.tag), 64'(rsp_o.tag));
            assert (rsp_o.quotient == want.quotient)
               else value_error("rsp_o.quotient", 64'(want.quotient), 64'(rsp_o.quotient));
            assert (rsp_o.remainder == want.remainder)
               else value_error("rsp_o.remainder", 64'(want.remainder),
                                64'(rsp_o.remainder));
            assert (rsp_o.dbz == want.dbz)
               else value_error("rsp_o.dbz", 64'(want.dbz), 64'(rsp_o.dbz));
            rx_credits--;
            pending_ret++;
            received++;
            if (received == HOLD_AT && !hold_done) begin
               hold_left = HOLD_CYCLES;  // long back-pressure stretch
               hold_done = 1'b1;
            end
         end
         if (rsp_credit_i) begin
            rx_credits++;
         end
      end
   end

   initial begin
      #(TIMEOUT);
      stop_with_failure("watchdog expired before all responses arrived");
   end

endmodule

`default_nettype wire
